//--- rtl/mm_pkg.sv
// Shared widths, SRAM word types and pipeline structs
// for the streaming matrix-multiply engine
`default_nettype none

package mm_pkg;

  // ---------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------
  localparam int sram_addr_w = 16;
  localparam int sram_data_w = 32;
  localparam int dim_w = 16;

  // Row count sits in the upper half of a header word
  localparam int hdr_rows_lsb = 16;

  // ---------------------------------------------------------------------
  // SRAM words
  // ---------------------------------------------------------------------
  typedef logic [sram_addr_w-1:0] sram_addr_t;
  typedef logic signed [sram_data_w-1:0] sram_data_t;

  // ---------------------------------------------------------------------
  // Pipeline structs
  // ---------------------------------------------------------------------
  // A is a_rows x inner, B is inner x b_cols
  typedef struct packed {
    logic [dim_w-1:0] a_rows;
    logic [dim_w-1:0] inner;
    logic [dim_w-1:0] b_cols;
  } mat_dims_t;

  // Travels with the operand pair read data
  typedef struct packed {
    logic valid;
    logic first;
    logic last;
  } term_tag_t;

  // One finished dot product
  typedef struct packed {
    logic       valid;
    sram_data_t value;
  } result_t;

  // Result SRAM write port
  typedef struct packed {
    logic       en;
    sram_addr_t addr;
    sram_data_t data;
  } sram_wr_t;

endpackage

`default_nettype wire

//--- rtl/mm_operand_sequencer.sv
// Operand sequencer: job handshake, header decode, i/j/k loop nest
// and operand SRAM read addressing with the aligned term tag
`timescale 1ns/100ps
`default_nettype none

module mm_operand_sequencer (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               dut_valid,
  output logic               dut_ready,
  output mm_pkg::sram_addr_t input_read_address,
  output mm_pkg::sram_addr_t weight_read_address,
  input  mm_pkg::sram_data_t input_read_data,
  input  mm_pkg::sram_data_t weight_read_data,
  output mm_pkg::mat_dims_t  dims,
  output mm_pkg::term_tag_t  tag,
  input  logic               job_done
);
  import mm_pkg::*;

  typedef enum logic [1:0] {
    idle,
    header,
    issue,
    drain
  } state_t;

  state_t state;

  logic [dim_w-1:0] i_cnt;
  logic [dim_w-1:0] j_cnt;
  logic [dim_w-1:0] k_cnt;
  sram_addr_t       row_base;
  sram_addr_t       w_addr;
  logic             start;
  logic             k_end;
  logic             j_end;
  logic             i_end;

  assign start = dut_valid && dut_ready;
  assign dut_ready = (state == idle);

  assign k_end = (k_cnt == dims.inner - 1'b1);
  assign j_end = (j_cnt == dims.b_cols - 1'b1);
  assign i_end = (i_cnt == dims.a_rows - 1'b1);

  // ---------------------------------------------------------------------
  // FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            state <= header;
          end
        end
        // Header words for address 0 arrive here
        header: begin
          state <= issue;
        end
        issue: begin
          if (k_end && j_end && i_end) begin
            state <= drain;
          end
        end
        // Wait for the last result write
        drain: begin
          if (job_done) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Row count in the upper half, column count in the lower half
  always_ff @(posedge clk) begin
    if (state == header) begin
      dims.a_rows <= input_read_data[hdr_rows_lsb +: dim_w];
      dims.inner  <= input_read_data[0 +: dim_w];
      dims.b_cols <= weight_read_data[0 +: dim_w];
    end
  end

  // ---------------------------------------------------------------------
  // Loop counters and read addresses
  // ---------------------------------------------------------------------
  // Operands start at address 1, both walks begin there
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      i_cnt    <= '0;
      j_cnt    <= '0;
      k_cnt    <= '0;
      row_base <= '0;
      w_addr   <= '0;
    end else if (start) begin
      row_base <= sram_addr_t'(1);
      w_addr   <= sram_addr_t'(1);
    end else if (state == issue) begin
      if (!k_end) begin
        k_cnt  <= k_cnt + 1'b1;
        w_addr <= w_addr + dims.b_cols;
      end else if (!j_end) begin
        k_cnt  <= '0;
        j_cnt  <= j_cnt + 1'b1;
        // Top of column j+1 of B
        w_addr <= sram_addr_t'(j_cnt) + sram_addr_t'(2);
      end else if (!i_end) begin
        k_cnt    <= '0;
        j_cnt    <= '0;
        i_cnt    <= i_cnt + 1'b1;
        row_base <= row_base + dims.inner;
        w_addr   <= sram_addr_t'(1);
      end else begin
        // Last pair, park on the header address
        k_cnt    <= '0;
        j_cnt    <= '0;
        i_cnt    <= '0;
        row_base <= '0;
        w_addr   <= '0;
      end
    end
  end

  assign input_read_address  = row_base + sram_addr_t'(k_cnt);
  assign weight_read_address = w_addr;

  // Tag lines up with the read data one cycle later
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tag <= '0;
    end else begin
      tag.valid <= (state == issue);
      tag.first <= (k_cnt == '0);
      tag.last  <= k_end;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mm_mac_unit.sv
// MAC unit: signed multiply-accumulate of operand pairs
// into 32-bit wrapping dot products
`timescale 1ns/100ps
`default_nettype none

module mm_mac_unit (
  input  logic               clk,
  input  logic               reset_n,
  input  mm_pkg::sram_data_t input_read_data,
  input  mm_pkg::sram_data_t weight_read_data,
  input  mm_pkg::term_tag_t  tag,
  output mm_pkg::result_t    result
);
  import mm_pkg::*;

  sram_data_t product;
  sram_data_t sum;
  sram_data_t acc;
  sram_data_t value_q;
  logic       valid_q;

  // ---------------------------------------------------------------------
  // Datapath
  // ---------------------------------------------------------------------
  // Low word of the product, sums wrap at 32 bits
  assign product = input_read_data * weight_read_data;

  // First term restarts the dot product
  assign sum = tag.first ? product : acc + product;

  always_ff @(posedge clk) begin
    if (tag.valid) begin
      acc <= sum;
    end
  end

  always_ff @(posedge clk) begin
    if (tag.valid && tag.last) begin
      value_q <= sum;
    end
  end

  // ---------------------------------------------------------------------
  // Result strobe
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= tag.valid && tag.last;
    end
  end

  assign result = '{valid: valid_q, value: value_q};

endmodule

`default_nettype wire

//--- rtl/mm_result_writer.sv
// Result writer: sequential result SRAM writes and job completion
`timescale 1ns/100ps
`default_nettype none

module mm_result_writer (
  input  logic              clk,
  input  logic              reset_n,
  input  mm_pkg::mat_dims_t dims,
  input  mm_pkg::result_t   result,
  output mm_pkg::sram_wr_t  result_write,
  output logic              job_done
);
  import mm_pkg::*;

  sram_addr_t         wr_addr;
  logic [2*dim_w-1:0] n_cells;
  logic               last_write;

  // C has a_rows x b_cols words
  assign n_cells = dims.a_rows * dims.b_cols;

  assign last_write = result.valid &&
                      ({{(2*dim_w - sram_addr_w){1'b0}}, wr_addr} == n_cells - 1'b1);

  // ---------------------------------------------------------------------
  // Address counter
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_addr  <= '0;
      job_done <= 1'b0;
    end else begin
      job_done <= last_write;
      if (last_write) begin
        // Next job starts at address 0 again
        wr_addr <= '0;
      end else if (result.valid) begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // Write goes out in the same cycle as the result
  assign result_write = '{en: result.valid, addr: wr_addr, data: result.value};

endmodule

`default_nettype wire

//--- rtl/mm_top.sv
// Matrix-multiply engine top level
// Sequencer, MAC unit and result writer on the SRAM ports
`timescale 1ns/100ps
`default_nettype none

module mm_top (
  input  logic               clk,
  input  logic               reset_n,

  // Job handshake
  input  logic               dut_valid,
  output logic               dut_ready,

  // Input SRAM
  output mm_pkg::sram_addr_t input_read_address,
  input  mm_pkg::sram_data_t input_read_data,

  // Weight SRAM
  output mm_pkg::sram_addr_t weight_read_address,
  input  mm_pkg::sram_data_t weight_read_data,

  // Result SRAM
  output mm_pkg::sram_wr_t   result_write
);
  import mm_pkg::*;

  mat_dims_t dims;
  term_tag_t tag;
  result_t   result;
  logic      job_done;

  // ---------------------------------------------------------------------
  // Decode
  // ---------------------------------------------------------------------
  mm_operand_sequencer u_sequencer (
    .clk                 (clk),
    .reset_n             (reset_n),
    .dut_valid           (dut_valid),
    .dut_ready           (dut_ready),
    .input_read_address  (input_read_address),
    .weight_read_address (weight_read_address),
    .input_read_data     (input_read_data),
    .weight_read_data    (weight_read_data),
    .dims                (dims),
    .tag                 (tag),
    .job_done            (job_done)
  );

  // ---------------------------------------------------------------------
  // Execute
  // ---------------------------------------------------------------------
  mm_mac_unit u_mac (
    .clk              (clk),
    .reset_n          (reset_n),
    .input_read_data  (input_read_data),
    .weight_read_data (weight_read_data),
    .tag              (tag),
    .result           (result)
  );

  // ---------------------------------------------------------------------
  // Write back
  // ---------------------------------------------------------------------
  mm_result_writer u_writer (
    .clk          (clk),
    .reset_n      (reset_n),
    .dims         (dims),
    .result       (result),
    .result_write (result_write),
    .job_done     (job_done)
  );

endmodule

`default_nettype wire

//--- tests/mm_top_chk.sv
// Protocol assertions for the matrix-multiply top level
// and the bind that attaches them to mm_top
`timescale 1ns/100ps
`default_nettype none

module mm_top_chk (
  input logic             clk,
  input logic             reset_n,
  input logic             dut_valid,
  input logic             dut_ready,
  input mm_pkg::sram_wr_t result_write
);
  import mm_pkg::*;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  sram_addr_t prev_addr;
  logic       seen_write;

  // Last write address of the current job, cleared while idle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prev_addr  <= '0;
      seen_write <= 1'b0;
    end else if (dut_ready) begin
      seen_write <= 1'b0;
    end else if (result_write.en) begin
      prev_addr  <= result_write.addr;
      seen_write <= 1'b1;
    end
  end

  // ---------------------------------------------------------------------
  // Properties
  // ---------------------------------------------------------------------
  no_write_while_ready: assert property (@(posedge clk) disable iff (!reset_n)
    !(result_write.en && dut_ready))
  else begin
    $error("result write while dut_ready is high");
    fail_count++;
  end

  ready_falls_after_start: assert property (@(posedge clk) disable iff (!reset_n)
    dut_valid && dut_ready |=> !dut_ready)
  else begin
    $error("dut_ready still high after an accepted dut_valid");
    fail_count++;
  end

  write_addr_steps_by_one: assert property (@(posedge clk) disable iff (!reset_n)
    result_write.en && seen_write |-> result_write.addr == sram_addr_t'(prev_addr + 1'b1))
  else begin
    $error("result write address did not follow the previous one");
    fail_count++;
  end

endmodule

bind mm_top mm_top_chk u_chk (
  .clk          (clk),
  .reset_n      (reset_n),
  .dut_valid    (dut_valid),
  .dut_ready    (dut_ready),
  .result_write (result_write)
);

`default_nettype wire

//--- tests/mm_tb.sv
// Testbench for the matrix-multiply engine: clock, reset, SRAM models,
// stimulus file reader, job driver, result and protocol checks, timeout
`timescale 1ns/100ps
`default_nettype none

module mm_tb;
  import mm_pkg::*;

  localparam int half_period = 20;
  localparam int reset_cycles = 3;
  localparam int max_gap = 5;
  localparam int mem_words = 1 << sram_addr_w;

  logic       clk;
  logic       reset_n;
  logic       dut_valid;
  logic       dut_ready;
  sram_addr_t input_read_address;
  sram_addr_t weight_read_address;
  sram_data_t input_read_data;
  sram_data_t weight_read_data;
  sram_wr_t   result_write;

  sram_data_t input_mem [mem_words];
  sram_data_t weight_mem [mem_words];
  sram_data_t result_mem [mem_words];

  // Cases from the stimulus file, operand words flattened
  mat_dims_t  case_dims [$];
  sram_data_t a_words [$];
  sram_data_t b_words [$];
  sram_data_t c_words [$];

  int cycle_count = 0;
  int timeout_limit = 0;

  mm_top UUT (
    .clk                 (clk),
    .reset_n             (reset_n),
    .dut_valid           (dut_valid),
    .dut_ready           (dut_ready),
    .input_read_address  (input_read_address),
    .input_read_data     (input_read_data),
    .weight_read_address (weight_read_address),
    .weight_read_data    (weight_read_data),
    .result_write        (result_write)
  );

  always #half_period clk = ~clk;

  // ---------------------------------------------------------------------
  // SRAM models, one cycle read latency
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    input_read_data  <= input_mem[input_read_address];
    weight_read_data <= weight_mem[weight_read_address];
    if (result_write.en) begin
      result_mem[result_write.addr] <= result_write.data;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      stop_with_failure($sformatf("Timeout after %0d cycles", cycle_count));
    end else if (UUT.u_chk.fail_count != 0) begin
      stop_with_failure("A bound protocol assertion on mm_top failed");
    end
  end

  // ---------------------------------------------------------------------
  // Reporting
  // ---------------------------------------------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    stop_with_failure($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                name, got, expected));
  endtask

  // ---------------------------------------------------------------------
  // Stimulus file
  // ---------------------------------------------------------------------
  // Next hex word, skipping comment lines
  task automatic read_word(input int fd, output logic [31:0] value, output bit found);
    string tok;
    string rest;
    int    n;
    found = 1'b0;
    value = '0;
    while (!found) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        return;
      end
      if (tok.getc(0) == "#") begin
        n = $fgets(rest, fd);
      end else if ($sscanf(tok, "%h", value) == 1) begin
        found = 1'b1;
      end else begin
        stop_with_failure({"Stimulus file holds a word that is not hex: ", tok});
      end
    end
  endtask

  task automatic read_case_word(input int fd, output logic [31:0] value);
    bit found;
    read_word(fd, value, found);
    if (!found) begin
      stop_with_failure("Stimulus file ends in the middle of a case");
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    int          work;
    bit          found;
    logic [31:0] word;
    mat_dims_t   d;
    fd = $fopen("tests/mm_stim.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Cannot open tests/mm_stim.txt");
    end
    work = 0;
    read_word(fd, word, found);
    while (found) begin
      d.a_rows = word[dim_w-1:0];
      read_case_word(fd, word);
      d.inner = word[dim_w-1:0];
      read_case_word(fd, word);
      d.b_cols = word[dim_w-1:0];
      if (d.a_rows == 0 || d.inner == 0 || d.b_cols == 0) begin
        stop_with_failure("Stimulus case has a zero dimension");
      end
      case_dims.push_back(d);
      for (n = 0; n < int'(d.a_rows) * int'(d.inner); n++) begin
        read_case_word(fd, word);
        a_words.push_back(word);
      end
      for (n = 0; n < int'(d.inner) * int'(d.b_cols); n++) begin
        read_case_word(fd, word);
        b_words.push_back(word);
      end
      for (n = 0; n < int'(d.a_rows) * int'(d.b_cols); n++) begin
        read_case_word(fd, word);
        c_words.push_back(word);
      end
      work += int'(d.a_rows) * int'(d.b_cols) * int'(d.inner) + 20;
      read_word(fd, word, found);
    end
    $fclose(fd);
    if (case_dims.size() == 0) begin
      stop_with_failure("Stimulus file holds no cases");
    end
    timeout_limit = work * 2;
  endtask

  // ---------------------------------------------------------------------
  // Job driver
  // ---------------------------------------------------------------------
  // Headers and operands of one case, result SRAM filled with a marker
  task automatic load_case(input mat_dims_t d, input int a_base, input int b_base);
    int n;
    input_mem[0]  = {d.a_rows, d.inner};
    weight_mem[0] = {d.inner, d.b_cols};
    for (n = 0; n < int'(d.a_rows) * int'(d.inner); n++) begin
      input_mem[n + 1] = a_words[a_base + n];
    end
    for (n = 0; n < int'(d.inner) * int'(d.b_cols); n++) begin
      weight_mem[n + 1] = b_words[b_base + n];
    end
    for (n = 0; n < mem_words; n++) begin
      result_mem[n] = sram_data_t'(32'h5a00_0000 ^ n);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the last write
  task automatic run_job(input mat_dims_t d, input int c_base);
    int n_cells;
    int writes;
    int n;
    n_cells = int'(d.a_rows) * int'(d.b_cols);
    dut_valid = 1'b1;
    while (!dut_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    dut_valid = 1'b0;
    assert (!dut_ready) else report_mismatch("dut_ready", dut_ready, 1'b0);
    writes = 0;
    while (writes < n_cells) begin
      if (result_write.en) begin
        assert (result_write.addr == sram_addr_t'(writes))
          else report_mismatch("result_write.addr", result_write.addr, writes);
        writes++;
      end
      assert (!dut_ready) else report_mismatch("dut_ready", dut_ready, 1'b0);
      @(negedge clk);
    end
    assert (!result_write.en)
      else stop_with_failure("More result writes than a_rows*b_cols in one job");
    for (n = 0; n < n_cells; n++) begin
      assert (result_mem[n] == c_words[c_base + n])
        else report_mismatch($sformatf("result_mem[%0d]", n), result_mem[n],
                             c_words[c_base + n]);
    end
  endtask

  initial begin
    int c;
    int gap;
    int a_base;
    int b_base;
    int c_base;
    clk = 1'b0;
    reset_n = 1'b0;
    dut_valid = 1'b0;
    input_read_data = '0;
    weight_read_data = '0;
    void'($urandom(6));
    load_stimulus();

    repeat (reset_cycles) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    assert (dut_ready) else report_mismatch("dut_ready", dut_ready, 1'b1);
    assert (!result_write.en) else report_mismatch("result_write.en", result_write.en, 1'b0);

    a_base = 0;
    b_base = 0;
    c_base = 0;
    for (c = 0; c < case_dims.size(); c++) begin
      load_case(case_dims[c], a_base, b_base);
      // Second job starts with dut_valid already high as dut_ready rises
      gap = (c == 1) ? 0 : int'($urandom % (max_gap + 1));
      repeat (gap) @(negedge clk);
      run_job(case_dims[c], c_base);
      a_base += int'(case_dims[c].a_rows) * int'(case_dims[c].inner);
      b_base += int'(case_dims[c].inner) * int'(case_dims[c].b_cols);
      c_base += int'(case_dims[c].a_rows) * int'(case_dims[c].b_cols);
    end

    repeat (3) @(negedge clk);
    if (UUT.u_chk.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_with_failure("A bound protocol assertion on mm_top failed");
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mm_pkg.sv
rtl/mm_operand_sequencer.sv
rtl/mm_mac_unit.sv
rtl/mm_result_writer.sv
rtl/mm_top.sv
tests/mm_top_chk.sv
tests/mm_tb.sv

//--- Bender.yml
package:
  name: mm_engine

sources:
  # Design
  - rtl/mm_pkg.sv
  - rtl/mm_operand_sequencer.sv
  - rtl/mm_mac_unit.sv
  - rtl/mm_result_writer.sv
  - rtl/mm_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/mm_top_chk.sv
      - tests/mm_tb.sv

//--- tests/mm_stim.txt
# Per case: a_rows inner b_cols, then A row-major, B row-major, expected C row-major
# All values in hex, 32-bit two's complement
# 1x1x1 with a negative operand
1 1 1
FFFFFFFD
5
FFFFFFF1
# 2x3 times 3x4
2 3 4
1 2 3
FFFFFFFF 4 FFFFFFFE
1 0 2 FFFFFFFF
3 1 0 2
FFFFFFFE 5 1 0
1 11 5 3
F FFFFFFFA FFFFFFFC 9
# inner = 1
3 1 2
2
FFFFFFFF
7
3 FFFFFFFC
6 FFFFFFF8
FFFFFFFD 4
15 FFFFFFE4
# a_rows = 1
1 4 3
1 2 3 4
1 2 3
4 5 6
7 8 9
A B C
46 50 5A
# Products and sums that wrap
2 2 2
40000000 40000000
7FFFFFFF 2
2 3
2 FFFFFFFF
0 80000000
2 7FFFFFFB
# 3x2 times 2x2
3 2 2
1 FFFFFFFF
2 3
FFFFFFFB 0
6 FFFFFFFE
1 4
5 FFFFFFFA
F 8
FFFFFFE2 A
